/* pe_array_defines.svh */
`ifndef PE_ARRAY_DEFINES_SVH
`define PE_ARRAY_DEFINES_SVH

// width of a phit on the stream and of every register-file word
`define PHIT_W 32

// number of processing-element columns, each one pipeline stage deep
`define NUM_COL 4

// configuration entries held by the table inside each column
`define CFG_DEPTH 8

// words held by the register file inside each column
`define RF_DEPTH 8

// address width shared by the configuration tables and the register files
// both depths above must fit in this many bits
`define ADDR_W 3

// width of the immediate field in a configuration entry
// the column sign-extends it to the phit width before use
`define IMM_W 16

`endif

/* pe_array_pkg.sv */
`include "pe_array_defines.svh"

package pe_array_pkg;

    // entry counts need one bit more than an address so a full table fits
    localparam int cnt_w = `ADDR_W + 1;

    // ALU opcode, mul keeps only the low half of the product
    typedef enum logic [1:0] {
        add    = 2'd0,
        sub    = 2'd1,
        mul    = 2'd2,
        pass_a = 2'd3
    } alu_op_e;

    // source of an ALU operand
    // sel_itr takes the iteration index that travels with the phit
    typedef enum logic [1:0] {
        sel_stream = 2'd0,
        sel_imm    = 2'd1,
        sel_rf     = 2'd2,
        sel_itr    = 2'd3
    } opnd_sel_e;

    // one configuration table entry, taken from the low bits of a control word
    // the first field declared sits at the top of the packed word
    typedef struct packed {
        logic                valid;
        alu_op_e             op;
        opnd_sel_e           sel_a;
        opnd_sel_e           sel_b;
        logic [`ADDR_W-1:0]  rf_wr_addr;
        logic [`ADDR_W-1:0]  rf_rd_addr;
        logic                rf_wr_en;
        logic [`IMM_W-1:0]   imm;
    } cfg_entry_t;

    // phit in flight between pipeline stages
    // the iteration index rides along so every column picks its entry locally
    typedef struct packed {
        logic                valid;
        logic [`PHIT_W-1:0]  itr;
        logic [`PHIT_W-1:0]  data;
    } phit_t;

    // data word at the output of every column, index 0 is the first column
    typedef logic [`NUM_COL-1:0][`PHIT_W-1:0] tap_array_t;

endpackage

/* ctrl_plane.sv */
`timescale 1ns/1ns
`include "pe_array_defines.svh"

module ctrl_plane (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_loader,
    input  logic                              start_stream_in,
    input  logic [`PHIT_W-1:0]                ctrl_plane_wr_data,
    input  logic [pe_array_pkg::cnt_w-1:0]    num_entry_config_table,
    input  logic [pe_array_pkg::cnt_w-1:0]    num_entry_inbound,
    input  logic [`PHIT_W-1:0]                stream_in,
    output logic                              ready_stream_in,
    output logic                              stream_active,
    output logic [`NUM_COL-1:0]               cfg_wr_en,
    output logic [`ADDR_W-1:0]                cfg_wr_addr,
    output pe_array_pkg::cfg_entry_t          cfg_wr_data,
    output logic                              rf_load_en,
    output logic [`ADDR_W-1:0]                rf_load_addr,
    output logic [`PHIT_W-1:0]                rf_load_data,
    output logic [pe_array_pkg::cnt_w-1:0]    num_entry,
    output pe_array_pkg::phit_t               head
);

    import pe_array_pkg::*;

    // a single column still needs a one-bit column counter
    localparam int col_w = (`NUM_COL > 1) ? $clog2(`NUM_COL) : 1;

    typedef enum logic [2:0] {
        idle,
        load_cfg,
        load_rf,
        wait_start,
        wait_release,
        streaming
    } state_e;

    state_e                 state;
    logic [col_w-1:0]       col_cnt;
    logic [`ADDR_W-1:0]     ent_cnt;
    logic [`ADDR_W-1:0]     rf_cnt;
    logic [cnt_w-1:0]       num_cfg_q;
    logic [cnt_w-1:0]       num_rf_q;
    logic [`PHIT_W-1:0]     itr_cnt;

    // the load sequencer walks the configuration words column by column
    // and then the preload words, one word per clock with no gaps
    // a start pulse in any state restarts it, which also closes an open stream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            col_cnt   <= '0;
            ent_cnt   <= '0;
            rf_cnt    <= '0;
            num_cfg_q <= '0;
            num_rf_q  <= '0;
            itr_cnt   <= '0;
        end else if (start_loader) begin
            // counts are captured here and hold until the next load
            num_cfg_q <= num_entry_config_table;
            num_rf_q  <= num_entry_inbound;
            col_cnt   <= '0;
            ent_cnt   <= '0;
            rf_cnt    <= '0;
            // empty windows are skipped so no cycle is spent on them
            if (num_entry_config_table != '0) begin
                state <= load_cfg;
            end else if (num_entry_inbound != '0) begin
                state <= load_rf;
            end else begin
                state <= wait_start;
            end
        end else begin
            case (state)
                load_cfg: begin
                    // last entry of this column moves on to the next column
                    if ({1'b0, ent_cnt} == num_cfg_q - 1'b1) begin
                        ent_cnt <= '0;
                        if (col_cnt == col_w'(`NUM_COL - 1)) begin
                            state <= (num_rf_q != '0) ? load_rf : wait_start;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end else begin
                        ent_cnt <= ent_cnt + 1'b1;
                    end
                end
                load_rf: begin
                    if ({1'b0, rf_cnt} == num_rf_q - 1'b1) begin
                        state <= wait_start;
                    end else begin
                        rf_cnt <= rf_cnt + 1'b1;
                    end
                end
                wait_start: begin
                    // ready is up here, the source answers with start
                    if (start_stream_in) begin
                        state <= wait_release;
                    end
                end
                wait_release: begin
                    // the stream opens once start has been dropped again
                    if (!start_stream_in) begin
                        state   <= streaming;
                        itr_cnt <= '0;
                    end
                end
                streaming: begin
                    itr_cnt <= itr_cnt + 1'b1;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // the head register stamps every phit with its iteration index
    // it adds the one cycle between stream_in and the first column
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head <= '0;
        end else begin
            head.valid <= (state == streaming);
            head.itr   <= itr_cnt;
            head.data  <= stream_in;
        end
    end

    assign ready_stream_in = (state == wait_start);
    assign stream_active   = (state == streaming);
    assign num_entry       = num_cfg_q;

    // configuration words go to one column at a time
    assign cfg_wr_en   = (state == load_cfg) ? (`NUM_COL'(1) << col_cnt) : '0;
    assign cfg_wr_addr = ent_cnt;
    assign cfg_wr_data = cfg_entry_t'(ctrl_plane_wr_data[$bits(cfg_entry_t)-1:0]);

    // preload words are broadcast, every column stores the same value
    assign rf_load_en   = (state == load_rf);
    assign rf_load_addr = rf_cnt;
    assign rf_load_data = ctrl_plane_wr_data;

    // the source keeps start low until the load windows are over
    a_no_start_in_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == load_cfg || state == load_rf) |-> !start_stream_in
    );

    // at most one column table is written on any clock
    a_cfg_wr_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(cfg_wr_en)
    );

endmodule

/* pe_column.sv */
`timescale 1ns/1ns
`include "pe_array_defines.svh"

module pe_column (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              stream_active,
    input  logic                              cfg_wr_en,
    input  logic [`ADDR_W-1:0]                cfg_wr_addr,
    input  pe_array_pkg::cfg_entry_t          cfg_wr_data,
    input  logic                              rf_load_en,
    input  logic [`ADDR_W-1:0]                rf_load_addr,
    input  logic [`PHIT_W-1:0]                rf_load_data,
    input  logic [pe_array_pkg::cnt_w-1:0]    num_entry,
    input  pe_array_pkg::phit_t               phit_in,
    output pe_array_pkg::phit_t               phit_out
);

    import pe_array_pkg::*;

    cfg_entry_t             cfg_tbl [`CFG_DEPTH];
    logic [`PHIT_W-1:0]     rf [`RF_DEPTH];

    logic [`PHIT_W-1:0]     itr_mod;
    logic [`ADDR_W-1:0]     ent_idx;
    cfg_entry_t             ent;
    logic [`PHIT_W-1:0]     imm_ext;
    logic [`PHIT_W-1:0]     rf_rd_data;
    logic [`PHIT_W-1:0]     opnd_a;
    logic [`PHIT_W-1:0]     opnd_b;
    logic [`PHIT_W-1:0]     alu_res;
    logic [`PHIT_W-1:0]     result;

    logic                   rf_we;
    logic [`ADDR_W-1:0]     rf_waddr;
    logic [`PHIT_W-1:0]     rf_wdata;

    // one multiplexer serves both operand ports
    function automatic logic [`PHIT_W-1:0] pick_opnd(
        input opnd_sel_e          sel,
        input logic [`PHIT_W-1:0] stream_word,
        input logic [`PHIT_W-1:0] imm_word,
        input logic [`PHIT_W-1:0] rf_word,
        input logic [`PHIT_W-1:0] itr_word
    );
        case (sel)
            sel_stream: pick_opnd = stream_word;
            sel_imm:    pick_opnd = imm_word;
            sel_rf:     pick_opnd = rf_word;
            default:    pick_opnd = itr_word;
        endcase
    endfunction

    // the entry index is the iteration index modulo the loaded entry count
    // an empty table leaves the index at zero and the entry is forced invalid
    always_comb begin
        itr_mod = '0;
        if (num_entry != '0) begin
            itr_mod = phit_in.itr % `PHIT_W'(num_entry);
        end
    end

    assign ent_idx = itr_mod[`ADDR_W-1:0];
    assign ent     = (num_entry != '0) ? cfg_tbl[ent_idx] : '0;

    // immediate is signed, so negative offsets work with add
    assign imm_ext    = {{(`PHIT_W - `IMM_W){ent.imm[`IMM_W-1]}}, ent.imm};
    assign rf_rd_data = rf[ent.rf_rd_addr];

    assign opnd_a = pick_opnd(ent.sel_a, phit_in.data, imm_ext, rf_rd_data, phit_in.itr);
    assign opnd_b = pick_opnd(ent.sel_b, phit_in.data, imm_ext, rf_rd_data, phit_in.itr);

    always_comb begin
        case (ent.op)
            add:     alu_res = opnd_a + opnd_b;
            sub:     alu_res = opnd_a - opnd_b;
            // only the low word of the product is kept
            mul:     alu_res = opnd_a * opnd_b;
            default: alu_res = opnd_a;
        endcase
    end

    // an invalid entry leaves the phit data untouched
    assign result = ent.valid ? alu_res : phit_in.data;

    // the register file has a single write port
    // outside the stream it takes preload words, inside it takes write-back
    always_comb begin
        if (stream_active) begin
            rf_we    = phit_in.valid & ent.valid & ent.rf_wr_en;
            rf_waddr = ent.rf_wr_addr;
            rf_wdata = alu_res;
        end else begin
            rf_we    = rf_load_en;
            rf_waddr = rf_load_addr;
            rf_wdata = rf_load_data;
        end
    end

    // tables are written only during the load phase
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CFG_DEPTH; i++) begin
                cfg_tbl[i] <= '0;
            end
        end else if (cfg_wr_en) begin
            cfg_tbl[cfg_wr_addr] <= cfg_wr_data;
        end
    end

    // write-back lands on the same edge that registers the phit
    // so the following phit already reads the new value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    // pipeline register of this stage, it keeps valid and itr as they came
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phit_out <= '0;
        end else begin
            phit_out.valid <= phit_in.valid;
            phit_out.itr   <= phit_in.itr;
            phit_out.data  <= result;
        end
    end

    // bubbles in the stream must never touch the register file
    a_no_rf_wr_on_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stream_active && !phit_in.valid) |-> !rf_we
    );

endmodule

/* pe_array_top.sv */
`timescale 1ns/1ns
`include "pe_array_defines.svh"

module pe_array_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_loader,
    input  logic                              start_stream_in,
    input  logic [`PHIT_W-1:0]                ctrl_plane_wr_data,
    input  logic [pe_array_pkg::cnt_w-1:0]    num_entry_config_table,
    input  logic [pe_array_pkg::cnt_w-1:0]    num_entry_inbound,
    input  logic [`PHIT_W-1:0]                stream_in,
    output logic                              ready_stream_in,
    output logic [`PHIT_W-1:0]                stream_out,
    output logic                              stream_out_valid,
    output pe_array_pkg::tap_array_t          stream_out_pe
);

    import pe_array_pkg::*;

    logic                   stream_active;
    logic [`NUM_COL-1:0]    cfg_wr_en;
    logic [`ADDR_W-1:0]     cfg_wr_addr;
    cfg_entry_t             cfg_wr_data;
    logic                   rf_load_en;
    logic [`ADDR_W-1:0]     rf_load_addr;
    logic [`PHIT_W-1:0]     rf_load_data;
    logic [cnt_w-1:0]       num_entry;

    // chain[0] is the head phit, chain[c+1] leaves column c
    phit_t                  chain [`NUM_COL+1];

    ctrl_plane u_ctrl (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .start_loader           (start_loader),
        .start_stream_in        (start_stream_in),
        .ctrl_plane_wr_data     (ctrl_plane_wr_data),
        .num_entry_config_table (num_entry_config_table),
        .num_entry_inbound      (num_entry_inbound),
        .stream_in              (stream_in),
        .ready_stream_in        (ready_stream_in),
        .stream_active          (stream_active),
        .cfg_wr_en              (cfg_wr_en),
        .cfg_wr_addr            (cfg_wr_addr),
        .cfg_wr_data            (cfg_wr_data),
        .rf_load_en             (rf_load_en),
        .rf_load_addr           (rf_load_addr),
        .rf_load_data           (rf_load_data),
        .num_entry              (num_entry),
        .head                   (chain[0])
    );

    // each column gets its own table enable, everything else is shared
    for (genvar c = 0; c < `NUM_COL; c++) begin : g_col
        pe_column u_col (
            .clk           (clk),
            .rst_n         (rst_n),
            .stream_active (stream_active),
            .cfg_wr_en     (cfg_wr_en[c]),
            .cfg_wr_addr   (cfg_wr_addr),
            .cfg_wr_data   (cfg_wr_data),
            .rf_load_en    (rf_load_en),
            .rf_load_addr  (rf_load_addr),
            .rf_load_data  (rf_load_data),
            .num_entry     (num_entry),
            .phit_in       (chain[c]),
            .phit_out      (chain[c+1])
        );

        // tap of this column for observation
        assign stream_out_pe[c] = chain[c+1].data;
    end

    assign stream_out       = chain[`NUM_COL].data;
    assign stream_out_valid = chain[`NUM_COL].valid;

endmodule

/* tb_pe_array.sv */
`timescale 1ns/1ns
`include "pe_array_defines.svh"

module tb_pe_array;

    import pe_array_pkg::*;

    localparam int clk_period = 4;
    localparam int max_phits  = 32;
    localparam int hs_limit   = 16;
    // every load word and phit of all tests, plus handshake and drain for each stream
    localparam int load_words = (4 + 1 + 1 + 3 + 5 + 7) * `NUM_COL + 6 * `RF_DEPTH;
    localparam int phit_count = 12 + 16 + 16 + 20 + 10 + 10;
    localparam int run_cycles = 10 + load_words + phit_count + 6 * (`NUM_COL + 8);
    localparam int margin     = 4;

    logic                  clk;
    logic                  rst_n;
    logic                  start_loader;
    logic                  start_stream_in;
    logic [`PHIT_W-1:0]    ctrl_plane_wr_data;
    logic [cnt_w-1:0]      num_entry_config_table;
    logic [cnt_w-1:0]      num_entry_inbound;
    logic [`PHIT_W-1:0]    stream_in;
    logic                  ready_stream_in;
    logic [`PHIT_W-1:0]    stream_out;
    logic                  stream_out_valid;
    tap_array_t            stream_out_pe;

    // reference model of the tables and register files of every column
    cfg_entry_t            mdl_cfg [`NUM_COL][`CFG_DEPTH];
    logic [`PHIT_W-1:0]    mdl_rf [`NUM_COL][`RF_DEPTH];
    logic [`PHIT_W-1:0]    preload [`RF_DEPTH];
    logic [`PHIT_W-1:0]    stim [max_phits];
    // exp_res[k][c] is the output of column c for phit k
    tap_array_t            exp_res [max_phits];

    pe_array_top UUT (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .start_loader           (start_loader),
        .start_stream_in        (start_stream_in),
        .ctrl_plane_wr_data     (ctrl_plane_wr_data),
        .num_entry_config_table (num_entry_config_table),
        .num_entry_inbound      (num_entry_inbound),
        .stream_in              (stream_in),
        .ready_stream_in        (ready_stream_in),
        .stream_out             (stream_out),
        .stream_out_valid       (stream_out_valid),
        .stream_out_pe          (stream_out_pe)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(run_cycles * margin * clk_period);
        $display("Watchdog expired, the tests did not finish in %0d ns",
                 run_cycles * margin * clk_period);
        $display("Verification failed");
        $fatal(1, "watchdog timeout");
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [`PHIT_W-1:0] got,
                              input logic [`PHIT_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_taps(input string name, input tap_array_t got, input tap_array_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic cfg_entry_t make_entry(input alu_op_e op, input opnd_sel_e sel_a,
                                              input opnd_sel_e sel_b, input int rd,
                                              input int wr, input logic wr_en,
                                              input logic [`IMM_W-1:0] imm);
        cfg_entry_t e;
        e.valid      = 1'b1;
        e.op         = op;
        e.sel_a      = sel_a;
        e.sel_b      = sel_b;
        e.rf_wr_addr = wr[`ADDR_W-1:0];
        e.rf_rd_addr = rd[`ADDR_W-1:0];
        e.rf_wr_en   = wr_en;
        e.imm        = imm;
        return e;
    endfunction

    function automatic logic [`PHIT_W-1:0] opnd_value(input opnd_sel_e sel,
            input logic [`PHIT_W-1:0] data, input logic [`PHIT_W-1:0] imm32,
            input logic [`PHIT_W-1:0] rf_word, input logic [`PHIT_W-1:0] itr);
        case (sel)
            sel_stream: return data;
            sel_imm:    return imm32;
            sel_rf:     return rf_word;
            default:    return itr;
        endcase
    endfunction

    // one column applied to one phit, the write-back updates the model register file
    task automatic eval_column(input int c, input int n_cfg, input logic [`PHIT_W-1:0] itr,
                               input logic [`PHIT_W-1:0] din,
                               output logic [`PHIT_W-1:0] dout);
        cfg_entry_t            e;
        logic [`PHIT_W-1:0]    imm32;
        logic [`PHIT_W-1:0]    a;
        logic [`PHIT_W-1:0]    b;
        logic [`PHIT_W-1:0]    r;
        logic [2*`PHIT_W-1:0]  prod;
        e     = (n_cfg == 0) ? cfg_entry_t'('0) : mdl_cfg[c][itr % n_cfg];
        imm32 = `PHIT_W'($signed(e.imm));
        a     = opnd_value(e.sel_a, din, imm32, mdl_rf[c][e.rf_rd_addr], itr);
        b     = opnd_value(e.sel_b, din, imm32, mdl_rf[c][e.rf_rd_addr], itr);
        prod  = (2*`PHIT_W)'(a) * (2*`PHIT_W)'(b);
        case (e.op)
            add:     r = a + b;
            sub:     r = a - b;
            mul:     r = prod[`PHIT_W-1:0];
            default: r = a;
        endcase
        dout = e.valid ? r : din;
        if (e.valid && e.rf_wr_en) begin
            mdl_rf[c][e.rf_wr_addr] = r;
        end
    endtask

    task automatic predict_stream(input int n_cfg, input int n_phits);
        logic [`PHIT_W-1:0] din;
        logic [`PHIT_W-1:0] dout;
        for (int c = 0; c < `NUM_COL; c++) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                mdl_rf[c][i] = preload[i];
            end
        end
        for (int k = 0; k < n_phits; k++) begin
            for (int c = 0; c < `NUM_COL; c++) begin
                din = (c == 0) ? stim[k] : exp_res[k][c-1];
                eval_column(c, n_cfg, `PHIT_W'(k), din, dout);
                exp_res[k][c] = dout;
            end
        end
    endtask

    // start pulse, then column-major table words, then one preload word per address
    task automatic load_tables(input int n_cfg);
        @(negedge clk);
        start_loader           = 1'b1;
        num_entry_config_table = cnt_w'(n_cfg);
        num_entry_inbound      = cnt_w'(`RF_DEPTH);
        @(negedge clk);
        start_loader = 1'b0;
        for (int c = 0; c < `NUM_COL; c++) begin
            for (int e = 0; e < n_cfg; e++) begin
                ctrl_plane_wr_data = `PHIT_W'(mdl_cfg[c][e]);
                check_word("ready_stream_in", `PHIT_W'(ready_stream_in), '0);
                @(negedge clk);
            end
        end
        for (int i = 0; i < `RF_DEPTH; i++) begin
            ctrl_plane_wr_data = preload[i];
            check_word("ready_stream_in", `PHIT_W'(ready_stream_in), '0);
            @(negedge clk);
        end
        ctrl_plane_wr_data = '0;
        // ready comes up on the cycle right after the last load word
        check_word("ready_stream_in", `PHIT_W'(ready_stream_in), `PHIT_W'(1));
    endtask

    task automatic open_stream();
        int waited;
        waited = 0;
        while (ready_stream_in !== 1'b1) begin
            if (waited == hs_limit) begin
                report_failure("ready_stream_in did not rise after the load");
            end
            @(negedge clk);
            waited++;
        end
        start_stream_in = 1'b1;
        @(negedge clk);
        waited = 0;
        while (ready_stream_in !== 1'b0) begin
            if (waited == hs_limit) begin
                report_failure("ready_stream_in stayed high after start_stream_in rose");
            end
            @(negedge clk);
            waited++;
        end
        start_stream_in = 1'b0;
        @(negedge clk);
        check_word("ready_stream_in", `PHIT_W'(ready_stream_in), '0);
    endtask

    // phit j is sampled at edge t0+j, tap c shows it after edge t0+j+1+c
    task automatic stream_and_check(input int n_phits);
        int          so_k;
        int          k;
        tap_array_t  exp_taps;
        for (int j = 0; j <= n_phits + `NUM_COL; j++) begin
            so_k = j - 1 - `NUM_COL;
            check_word("stream_out_valid", `PHIT_W'(stream_out_valid), `PHIT_W'(so_k >= 0));
            if (so_k >= 0) begin
                check_word("stream_out", stream_out, exp_res[so_k][`NUM_COL-1]);
            end
            if (j - 1 - `NUM_COL >= 0 && j - 2 < n_phits) begin
                for (int c = 0; c < `NUM_COL; c++) begin
                    exp_taps[c] = exp_res[j-2-c][c];
                end
                check_taps("stream_out_pe", stream_out_pe, exp_taps);
            end else begin
                for (int c = 0; c < `NUM_COL; c++) begin
                    k = j - 2 - c;
                    if (k >= 0 && k < n_phits) begin
                        check_word($sformatf("stream_out_pe[%0d]", c), stream_out_pe[c],
                                   exp_res[k][c]);
                    end
                end
            end
            stream_in = (j < n_phits) ? stim[j] : '0;
            @(negedge clk);
        end
    endtask

    // the stream stays open afterwards, the next load closes it
    task automatic run_stream(input int n_cfg, input int n_phits);
        for (int k = 0; k < n_phits; k++) begin
            stim[k] = $urandom;
        end
        predict_stream(n_cfg, n_phits);
        load_tables(n_cfg);
        open_stream();
        stream_and_check(n_phits);
    endtask

    task automatic fill_tables(input logic random_fill);
        logic [`PHIT_W-1:0] r;
        for (int c = 0; c < `NUM_COL; c++) begin
            for (int e = 0; e < `CFG_DEPTH; e++) begin
                r = random_fill ? $urandom : '0;
                mdl_cfg[c][e] = r[$bits(cfg_entry_t)-1:0];
            end
        end
        for (int i = 0; i < `RF_DEPTH; i++) begin
            preload[i] = $urandom;
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_word("ready_stream_in", `PHIT_W'(ready_stream_in), '0);
        check_word("stream_out_valid", `PHIT_W'(stream_out_valid), '0);
        check_taps("stream_out_pe", stream_out_pe, '0);
    endtask

    task automatic test_pass_through();
        fill_tables(1'b0);
        run_stream(4, 12);
    endtask

    task automatic test_alu_ops();
        fill_tables(1'b0);
        // negative immediates exercise the sign extension
        mdl_cfg[0][0] = make_entry(add, sel_stream, sel_imm, 0, 0, 1'b0, 16'hff80);
        mdl_cfg[1][0] = make_entry(sub, sel_stream, sel_imm, 0, 0, 1'b0, 16'h0123);
        mdl_cfg[2][0] = make_entry(mul, sel_stream, sel_imm, 0, 0, 1'b0, 16'h9e37);
        mdl_cfg[3][0] = make_entry(pass_a, sel_stream, sel_imm, 0, 0, 1'b0, 16'h7777);
        run_stream(1, 16);
    endtask

    task automatic test_register_file();
        fill_tables(1'b0);
        mdl_cfg[0][0] = make_entry(add, sel_stream, sel_rf, 2, 0, 1'b0, '0);
        // column 1 accumulates into address 3 across consecutive phits
        mdl_cfg[1][0] = make_entry(add, sel_rf, sel_stream, 3, 3, 1'b1, '0);
        mdl_cfg[2][0] = make_entry(sub, sel_stream, sel_rf, 5, 0, 1'b0, '0);
        mdl_cfg[3][0] = make_entry(add, sel_rf, sel_rf, 6, 6, 1'b1, '0);
        run_stream(1, 16);
    endtask

    task automatic test_entry_cycling();
        fill_tables(1'b1);
        mdl_cfg[0][0] = make_entry(pass_a, sel_itr, sel_stream, 0, 0, 1'b0, '0);
        mdl_cfg[0][1] = make_entry(add, sel_stream, sel_imm, 0, 0, 1'b0, 16'h0100);
        mdl_cfg[0][2] = make_entry(sub, sel_stream, sel_itr, 0, 0, 1'b0, '0);
        mdl_cfg[1][0] = make_entry(add, sel_stream, sel_itr, 0, 0, 1'b0, '0);
        mdl_cfg[1][1] = '0;
        mdl_cfg[1][2] = make_entry(mul, sel_stream, sel_imm, 0, 0, 1'b0, 16'h0003);
        run_stream(3, 20);
    endtask

    task automatic test_reload();
        fill_tables(1'b1);
        run_stream(5, 10);
        fill_tables(1'b1);
        // the last column shows the iteration index, which restarts at zero
        mdl_cfg[3][0] = make_entry(pass_a, sel_itr, sel_stream, 0, 0, 1'b0, '0);
        run_stream(7, 10);
    endtask

    initial begin
        void'($urandom(46673));
        rst_n                  = 1'b0;
        start_loader           = 1'b0;
        start_stream_in        = 1'b0;
        ctrl_plane_wr_data     = '0;
        num_entry_config_table = '0;
        num_entry_inbound      = '0;
        stream_in              = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_pass_through();
        test_alu_ops();
        test_register_file();
        test_entry_cycling();
        test_reload();
        $display("Verification passed");
        $finish;
    end

endmodule

/* pe_array_top.f */
+incdir+.
pe_array_pkg.sv
ctrl_plane.sv
pe_column.sv
pe_array_top.sv
tb_pe_array.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pe_array
FILELIST  ?= pe_array_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build and run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Verification passed" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
